// ==== sources.f ====
hw/loader_pkg.sv
hw/ines_header_decode.sv
hw/image_writer.sv
hw/mem_write_slot.sv
hw/rom_loader_top.sv
test/rom_loader_assertions.sv
test/tb_rom_loader.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the loader testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rom_loader \
  -f sources.f -o sim_rom_loader > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/sim_rom_loader 2>&1 | tee sim.log

grep -q "^Testbench passed$" sim.log && echo "Simulation run passed" \
  || { echo "Simulation run did not pass"; exit 1; }

// ==== test/tb_rom_loader.sv ====
// ----------------------------------------
// Testbench for the cartridge image loader
// Streams headers and LFSR images from a case table
// ----------------------------------------
`timescale 1ns/100ps

module tb_rom_loader
  import loader_pkg::*;
();

  localparam int PRG_UNIT_BITS = 4;               // 16 byte program units
  localparam int CHR_UNIT_BITS = 3;               // 8 byte character units
  localparam int NUM_CASES     = 10;
  localparam int EXTRA_BYTES   = 4;               // Sent after the image, must be ignored

  typedef struct {
    string         name;
    bit            magic;                         // 0 corrupts magic byte 3
    byte_t         b4;
    byte_t         b5;
    byte_t         b6;
    byte_t         b7;
    mapper_flags_t flags;                         // Expected flag word
    logic          error;                         // Expected error level
    int            abort_after;                   // Image bytes before a mid load reset
  } test_case_t;

  logic          clk = 1'b0;
  logic          reset;
  byte_t         in_data;
  logic          in_strobe;
  rom_addr_t     mem_addr;
  byte_t         mem_data;
  logic          mem_write;
  mapper_flags_t mapper_flags;
  logic          done;
  logic          error;

  test_case_t    cases [NUM_CASES];
  rom_addr_t     exp_addr_q [$];                  // Reference write stream
  byte_t         exp_data_q [$];
  logic [31:0]   lfsr;
  string         cur_name;
  int            checks;
  int            errors;
  int            writes_seen;
  int            writes_due;
  int            cycles = 0;
  int            cycle_limit;

  rom_loader_top #(
    .PRG_UNIT_BITS (PRG_UNIT_BITS),
    .CHR_UNIT_BITS (CHR_UNIT_BITS)
  ) i_rom_loader_top (
    .clk          (clk),
    .reset        (reset),
    .in_data      (in_data),
    .in_strobe    (in_strobe),
    .mem_addr     (mem_addr),
    .mem_data     (mem_data),
    .mem_write    (mem_write),
    .mapper_flags (mapper_flags),
    .done         (done),
    .error        (error)
  );

  always #2 clk = ~clk;                           // 4 ns period

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d clocks in case %s", cycles, cur_name);
      $display("Testbench failed");
      $finish;
    end
  end

  task automatic check_byte(input string what, input byte_t exp, input byte_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s %s: expected %h, actual %h", cur_name, what, exp, act);
    end
  endtask

  task automatic check_addr(input string what, input rom_addr_t exp, input rom_addr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s %s: expected %h, actual %h", cur_name, what, exp, act);
    end
  endtask

  task automatic check_flags(input string what, input mapper_flags_t exp,
                             input mapper_flags_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s %s: expected %h, actual %h", cur_name, what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s %s: expected %b, actual %b", cur_name, what, exp, act);
    end
  endtask

  task automatic note_error(input string msg);
    errors++;
    $display("%s: %s", cur_name, msg);
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic next_byte(output byte_t b);
    b = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_step(lfsr);
      b    = {b[6:0], lfsr[0]};                   // One step per bit
    end
  endtask

  task automatic add_case(input int idx, input string name, input bit magic,
                          input byte_t b4, input byte_t b5, input byte_t b6, input byte_t b7,
                          input mapper_flags_t flags, input logic err, input int abort_after);
    cases[idx].name        = name;
    cases[idx].magic       = magic;
    cases[idx].b4          = b4;
    cases[idx].b5          = b5;
    cases[idx].b6          = b6;
    cases[idx].b7          = b7;
    cases[idx].flags       = flags;
    cases[idx].error       = err;
    cases[idx].abort_after = abort_after;
  endtask

  function automatic int prg_bytes(input int idx);
    return int'(cases[idx].b4) << PRG_UNIT_BITS;
  endfunction

  function automatic int chr_bytes(input int idx);
    return int'(cases[idx].b5) << CHR_UNIT_BITS;
  endfunction

  // Every strobe of a case, header included
  function automatic int case_bytes(input int idx);
    int total;
    total = HEADER_BYTES + prg_bytes(idx) + chr_bytes(idx) + EXTRA_BYTES;
    if (cases[idx].abort_after > 0)
      total += HEADER_BYTES + cases[idx].abort_after;
    return total;
  endfunction

  // Called and returns on a falling edge, 5 clocks per byte
  task automatic send_byte(input byte_t d);
    in_data   = d;
    in_strobe = 1'b1;
    @(negedge clk);
    in_strobe = 1'b0;
    repeat (4) @(negedge clk);
  endtask

  task automatic apply_reset();
    reset     = 1'b1;
    in_strobe = 1'b0;
    repeat (2) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
  endtask

  task automatic send_header(input int idx);
    byte_t hdr [HEADER_BYTES];
    for (int i = 0; i < HEADER_BYTES; i++)
      hdr[i] = 8'h00;
    hdr[0] = "N";
    hdr[1] = "E";
    hdr[2] = "S";
    hdr[3] = cases[idx].magic ? 8'h1A : 8'h1B;
    hdr[4] = cases[idx].b4;
    hdr[5] = cases[idx].b5;
    hdr[6] = cases[idx].b6;
    hdr[7] = cases[idx].b7;
    for (int i = 0; i < HEADER_BYTES; i++)
      send_byte(hdr[i]);
  endtask

  // Image bytes plus the reference model of the writes they cause
  task automatic stream_image(input int idx, input int count);
    int    prg;
    int    chr;
    byte_t d;
    prg = prg_bytes(idx);
    chr = chr_bytes(idx);
    for (int i = 0; i < count; i++) begin
      next_byte(d);
      if (!cases[idx].error && i < prg + chr) begin
        // PRG from zero, CHR from bit 21
        exp_addr_q.push_back(i < prg ? rom_addr_t'(i) : CHR_BASE + rom_addr_t'(i - prg));
        exp_data_q.push_back(d);
        writes_due++;
      end
      send_byte(d);
    end
  endtask

  task automatic drain_writes();
    while (exp_addr_q.size() != 0)
      @(negedge clk);
    repeat (8) @(negedge clk);                    // Room for a stray write
  endtask

  // Compares every memory write with the reference queue
  task automatic watch_writes();
    rom_addr_t a;
    byte_t     d;
    forever begin
      @(negedge clk);
      if (mem_write === 1'b1) begin
        writes_seen++;
        if (exp_addr_q.size() == 0) begin
          note_error($sformatf("unexpected memory write to address %h", mem_addr));
        end else begin
          a = exp_addr_q.pop_front();
          d = exp_data_q.pop_front();
          check_addr("mem_addr", a, mem_addr);
          check_byte("mem_data", d, mem_data);
        end
      end
    end
  endtask

  task automatic run_case(input int idx);
    int errors_before;
    errors_before = errors;
    cur_name      = cases[idx].name;
    writes_seen   = 0;
    writes_due    = 0;
    apply_reset();
    check_bit("done after reset", 1'b0, done);
    check_bit("error after reset", 1'b0, error);
    if (cases[idx].abort_after > 0) begin
      send_header(idx);                           // Partial load first
      stream_image(idx, cases[idx].abort_after);
      drain_writes();
      apply_reset();
    end
    send_header(idx);
    check_flags("mapper_flags", cases[idx].flags, mapper_flags);
    check_bit("error after header", cases[idx].error, error);
    check_bit("done after header", 1'b0, done);
    stream_image(idx, prg_bytes(idx) + chr_bytes(idx) + EXTRA_BYTES);
    drain_writes();
    check_bit("done at end", !cases[idx].error, done);
    check_bit("error at end", cases[idx].error, error);
    if (writes_seen != writes_due)
      note_error($sformatf("saw %0d memory writes where %0d were due", writes_seen, writes_due));
    $display("%s: %s, %0d writes", cur_name,
             (errors == errors_before) ? "ok" : "FAILED", writes_seen);
  endtask

  initial begin
    int total;
    reset     = 1'b1;
    in_strobe = 1'b0;
    in_data   = '0;
    lfsr      = 32'hc97bd2f6;
    checks    = 0;
    errors    = 0;
    cur_name  = "startup";
    // Flags are {chr_ram, vertical, chr code, prg code, mapper} in the low 16 bits
    add_case(0, "basic",        1, 8'd2,   8'd1, 8'h00, 8'h00, 32'h0000_0100, 0, 0);
    add_case(1, "mapper_42",    1, 8'd1,   8'd1, 8'h21, 8'h40, 32'h0000_4042, 0, 0);
    add_case(2, "prg_3",        1, 8'd3,   8'd1, 8'h00, 8'h00, 32'h0000_0200, 0, 0);
    add_case(3, "prg_64",       1, 8'd64,  8'd2, 8'h00, 8'h00, 32'h0000_0E00, 0, 0);
    add_case(4, "prg_200",      1, 8'd200, 8'd1, 8'h00, 8'h00, 32'h0000_0700, 0, 0);
    add_case(5, "chr_ram",      1, 8'd1,   8'd0, 8'h01, 8'h00, 32'h0000_C000, 0, 0);
    add_case(6, "bad_magic",    0, 8'd2,   8'd1, 8'h00, 8'h00, 32'h0000_0100, 1, 0);
    add_case(7, "trainer",      1, 8'd1,   8'd1, 8'h04, 8'h00, 32'h0000_0000, 1, 0);
    add_case(8, "four_screen",  1, 8'd1,   8'd1, 8'h08, 8'h00, 32'h0000_0000, 1, 0);
    add_case(9, "abort_reload", 1, 8'd2,   8'd1, 8'h00, 8'h00, 32'h0000_0100, 0, 10);
    total = 0;
    for (int i = 0; i < NUM_CASES; i++)
      total += case_bytes(i);
    cycle_limit = 5 * total + 100 * NUM_CASES;
    fork
      watch_writes();
    join_none
    @(negedge clk);
    for (int i = 0; i < NUM_CASES; i++)
      run_case(i);
    $display("Cases %0d, checks %0d, errors %0d", NUM_CASES, checks, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// ==== test/rom_loader_assertions.sv ====
// ----------------------------------------
// Protocol checks on the loader ports
// Bound into every rom_loader_top instance
// ----------------------------------------
`timescale 1ns/100ps

module rom_loader_assertions (
  input logic clk,
  input logic reset,
  input logic in_strobe,
  input logic mem_write,
  input logic done,
  input logic error
);

  // Source keeps strobes at least 4 clocks apart
  strobe_spacing: assert property (
    @(posedge clk) disable iff (reset)
      in_strobe |-> !$past(in_strobe, 1) && !$past(in_strobe, 2) && !$past(in_strobe, 3)
  ) else $error("in_strobe came less than 4 clocks after the previous strobe");

  // Write pulse is a single clock
  write_pulse: assert property (
    @(posedge clk) disable iff (reset) mem_write |=> !mem_write
  ) else $error("mem_write stayed high for more than one clock");

  // Terminal levels hold until reset
  done_sticky: assert property (
    @(posedge clk) disable iff (reset) done |=> done
  ) else $error("done dropped without a reset");

  error_sticky: assert property (
    @(posedge clk) disable iff (reset) error |=> error
  ) else $error("error dropped without a reset");

endmodule

bind rom_loader_top rom_loader_assertions i_rom_loader_assertions (
  .clk       (clk),
  .reset     (reset),
  .in_strobe (in_strobe),
  .mem_write (mem_write),
  .done      (done),
  .error     (error)
);

// ==== hw/rom_loader_top.sv ====
// ----------------------------------------
// Cartridge image loader top level
// Header decode, image writer and memory slot in a chain
// ----------------------------------------
`timescale 1ns/100ps

module rom_loader_top
  import loader_pkg::*;
#(
  parameter int PRG_UNIT_BITS = 14,              // 16 KiB program units
  parameter int CHR_UNIT_BITS = 13               // 8 KiB character units
) (
  input  logic          clk,
  input  logic          reset,
  input  byte_t         in_data,
  input  logic          in_strobe,
  output rom_addr_t     mem_addr,
  output byte_t         mem_data,
  output logic          mem_write,
  output mapper_flags_t mapper_flags,
  output logic          done,
  output logic          error
);

  // Decoder to writer
  logic        header_ok;
  logic        header_bad;
  unit_count_t prg_units;
  unit_count_t chr_units;

  // Writer to slot
  logic        wr_req;
  rom_addr_t   wr_addr;
  byte_t       wr_data;

  ines_header_decode i_ines_header_decode (
    .clk          (clk),
    .reset        (reset),
    .in_data      (in_data),
    .in_strobe    (in_strobe),
    .header_ok    (header_ok),
    .header_bad   (header_bad),
    .prg_units    (prg_units),
    .chr_units    (chr_units),
    .mapper_flags (mapper_flags)                 // Straight to the console
  );

  image_writer #(
    .PRG_UNIT_BITS (PRG_UNIT_BITS),
    .CHR_UNIT_BITS (CHR_UNIT_BITS)
  ) i_image_writer (
    .clk        (clk),
    .reset      (reset),
    .in_data    (in_data),
    .in_strobe  (in_strobe),
    .header_ok  (header_ok),
    .header_bad (header_bad),
    .prg_units  (prg_units),
    .chr_units  (chr_units),
    .wr_req     (wr_req),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .done       (done),
    .error      (error)
  );

  mem_write_slot i_mem_write_slot (
    .clk       (clk),
    .reset     (reset),
    .wr_req    (wr_req),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .mem_addr  (mem_addr),
    .mem_data  (mem_data),
    .mem_write (mem_write)
  );

endmodule

// ==== hw/mem_write_slot.sv ====
// ----------------------------------------
// Holds one write and issues it in the memory slot
// The slot comes every fourth clock at phase 3
// ----------------------------------------
`timescale 1ns/100ps

module mem_write_slot
  import loader_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      wr_req,
  input  rom_addr_t wr_addr,
  input  byte_t     wr_data,
  output rom_addr_t mem_addr,
  output byte_t     mem_data,
  output logic      mem_write
);

  logic [1:0] phase;                             // Free running slot phase
  logic       pending;                           // Write waiting for its slot
  logic       slot;
  rom_addr_t  held_addr;
  byte_t      held_data;

  assign slot = (phase == 2'd3);

  // Phase, pending flag and write pulse
  always_ff @(posedge clk) begin
    if (reset) begin
      phase     <= '0;
      pending   <= 1'b0;
      mem_write <= 1'b0;
    end else begin
      phase     <= phase + 2'd1;
      mem_write <= slot && pending;              // High for one clock
      if (slot)
        pending <= 1'b0;
      if (wr_req)
        pending <= 1'b1;                         // New request wins over the clear
    end
  end

  // Latch on request
  always_ff @(posedge clk) begin
    if (wr_req) begin
      held_addr <= wr_addr;
      held_data <= wr_data;
    end
  end

  // Output copy taken in the slot
  // Stays put even if the next request lands during the pulse
  always_ff @(posedge clk) begin
    if (slot && pending) begin
      mem_addr <= held_addr;
      mem_data <= held_data;
    end
  end

endmodule

// ==== hw/image_writer.sv ====
// ----------------------------------------
// Writes the program and character sections after a good header
// One write request per strobe while bytes are left
// ----------------------------------------
`timescale 1ns/100ps

module image_writer
  import loader_pkg::*;
#(
  parameter int PRG_UNIT_BITS = 14,
  parameter int CHR_UNIT_BITS = 13
) (
  input  logic        clk,
  input  logic        reset,
  input  byte_t       in_data,
  input  logic        in_strobe,
  input  logic        header_ok,
  input  logic        header_bad,
  input  unit_count_t prg_units,
  input  unit_count_t chr_units,
  output logic        wr_req,
  output rom_addr_t   wr_addr,
  output byte_t       wr_data,
  output logic        done,
  output logic        error
);

  writer_state_t state;
  rom_addr_t     addr;                           // Next target address
  logic [21:0]   bytes_left;                     // Bytes still due in this section
  logic [21:0]   prg_bytes;
  logic [21:0]   chr_bytes;
  logic          loading;
  logic          write_now;

  // Section lengths in bytes
  assign prg_bytes = 22'(prg_units) << PRG_UNIT_BITS;
  assign chr_bytes = 22'(chr_units) << CHR_UNIT_BITS;

  assign loading   = (state == load_prg) || (state == load_chr);
  assign write_now = loading && in_strobe && (bytes_left != '0);

  // FSM with address and byte counter
  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= wait_header;
      wr_req     <= 1'b0;
      addr       <= '0;
      bytes_left <= '0;
    end else begin
      wr_req <= write_now;                       // One clock per accepted byte
      case (state)
        wait_header: begin
          if (header_bad) begin
            state <= failed;
          end else if (header_ok) begin
            state      <= load_prg;
            addr       <= '0;                    // PRG from address zero
            bytes_left <= prg_bytes;
          end
        end
        load_prg: begin
          if (bytes_left == '0) begin
            state      <= load_chr;
            addr       <= CHR_BASE;
            bytes_left <= chr_bytes;             // Zero for CHR RAM carts
          end
        end
        load_chr: begin
          if (bytes_left == '0)
            state <= finished;
        end
        default: begin
          state <= state;                        // Terminal until reset
        end
      endcase
      // Never coincides with a section change since bytes_left is nonzero
      if (write_now) begin
        addr       <= addr + 22'd1;
        bytes_left <= bytes_left - 22'd1;
      end
    end
  end

  // Request payload
  always_ff @(posedge clk) begin
    if (write_now) begin
      wr_addr <= addr;
      wr_data <= in_data;
    end
  end

  // Sticky status levels
  assign done  = (state == finished);
  assign error = (state == failed);

endmodule

// ==== hw/ines_header_decode.sv ====
// ----------------------------------------
// Captures the iNES header from the byte stream and decodes it
// Pulses header_ok or header_bad once the 16th byte is in
// ----------------------------------------
`timescale 1ns/100ps

module ines_header_decode
  import loader_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  byte_t         in_data,
  input  logic          in_strobe,
  output logic          header_ok,
  output logic          header_bad,
  output unit_count_t   prg_units,
  output unit_count_t   chr_units,
  output mapper_flags_t mapper_flags
);

  byte_t       ines [HEADER_BYTES];              // Raw header bytes
  logic [3:0]  byte_count;                       // Next header slot
  logic        header_full;                      // Capture stops here
  logic        capture;
  logic        magic_ok;
  logic        flags_ok;
  size_code_t  prg_code;
  size_code_t  chr_code;
  mapper_t     mapper;
  logic        chr_ram;
  logic        vertical;

  // Smallest power of two that holds the count, saturating at 7
  function automatic size_code_t size_code(unit_count_t units);
    size_code_t code;
    code = 3'd7;                                 // Anything above 64 units
    for (int i = 6; i >= 0; i--) begin
      if (units <= (unit_count_t'(1) << i))
        code = size_code_t'(i);                  // Keep the smallest fit
    end
    return code;
  endfunction

  assign capture = in_strobe && !header_full;

  // Header storage
  always_ff @(posedge clk) begin
    if (capture)
      ines[byte_count] <= in_data;
  end

  // Byte counter and verdict pulses
  always_ff @(posedge clk) begin
    if (reset) begin
      byte_count  <= '0;
      header_full <= 1'b0;
      header_ok   <= 1'b0;
      header_bad  <= 1'b0;
    end else begin
      header_ok  <= 1'b0;                        // Pulses by default
      header_bad <= 1'b0;
      if (capture) begin
        byte_count <= byte_count + 4'd1;
        if (byte_count == 4'(HEADER_BYTES - 1)) begin
          header_full <= 1'b1;
          // Bytes 0 to 6 are already stored by now
          header_ok  <= magic_ok && flags_ok;
          header_bad <= !(magic_ok && flags_ok);
        end
      end
    end
  end

  // Checks on the stored header
  assign magic_ok = ({ines[0], ines[1], ines[2], ines[3]} == INES_MAGIC);
  assign flags_ok = !ines[6][2] && !ines[6][3];  // Trainer and four screen not supported

  // Section sizes
  assign prg_units = ines[4];
  assign chr_units = ines[5];
  assign prg_code  = size_code(prg_units);
  assign chr_code  = size_code(chr_units);

  // Mapper fields
  assign mapper   = {ines[7][7:4], ines[6][7:4]}; // High nibble from byte 7
  assign vertical = ines[6][0];
  assign chr_ram  = (chr_units == '0);           // No CHR ROM means CHR RAM

  assign mapper_flags = {16'b0, chr_ram, vertical, chr_code, prg_code, mapper};

endmodule

// ==== hw/loader_pkg.sv ====
// ----------------------------------------
// Shared types and constants for the cartridge image loader
// Imported by every loader module
// ----------------------------------------
package loader_pkg;

  // One download or memory data byte
  typedef logic [7:0] byte_t;

  // Memory byte address
  typedef logic [21:0] rom_addr_t;

  // Rounded up power of two of units, capped at 7
  typedef logic [2:0] size_code_t;

  // Mapper number from header bytes 7 and 6
  typedef logic [7:0] mapper_t;

  // Flag word handed to the console core
  // {16'b0, chr_ram, vertical, chr size code, prg size code, mapper}
  typedef logic [31:0] mapper_flags_t;

  // Unit count from header byte 4 or 5
  typedef logic [7:0] unit_count_t;

  // Writer FSM
  typedef enum logic [2:0] {
    wait_header,  // Header bytes still coming in
    load_prg,     // Program section
    load_chr,     // Character section
    finished,     // Whole image written
    failed        // Header rejected
  } writer_state_t;

  // Magic bytes N, E, S, 0x1A with byte 0 in the top lane
  localparam logic [31:0] INES_MAGIC = 32'h4E45_531A;

  // Header length in bytes
  localparam int HEADER_BYTES = 16;

  // Character section start, only bit 21 set
  localparam rom_addr_t CHR_BASE = 22'h20_0000;

endpackage
